// File: list.f
src/lsu_pkg.sv
src/lsu_req_decode.sv
src/lsu_bus_ctrl.sv
src/lsu_rdata_align.sv
src/lsu_top.sv
tests/tb_lsu.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_lsu -o sim_lsu

out="$(./obj_dir/sim_lsu 2>&1 || true)"
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
  exit 0
fi
exit 1

// File: tests/tb_lsu.sv
// Load/store unit testbench

`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

  localparam int unsigned SEED = 32'ha0f0;

  logic  clk, rst_n, valid_i, ready_o, we_i, sext_i;
  logic  bus_req_o, bus_we_o, bus_gnt_i, bus_rvalid_i, rvalid_o, busy_o;
  addr_t base_i, offset_i, bus_addr_o;
  size_t size_i;
  data_t wdata_i, bus_wdata_o, bus_rdata_i, rdata_o;
  be_t   bus_be_o;

  integer     seed;
  integer     bus_seed;
  string      test_name;
  logic       slow_mode = 1'b0;
  // Memory behind the bus and the reference copy
  logic [7:0] mem_bytes [256];
  logic [7:0] model_bytes [256];
  // Expected results, one per accepted operation
  logic       exp_we [$];
  data_t      exp_data [$];
  // Pending bus responses with their due cycle
  data_t      rsp_data [$];
  int         rsp_due [$];

  lsu_top i_lsu_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers and compare tasks
  //////////////////////////////////////////////////

  function automatic data_t rand32(inout integer s);
    integer r;
    r = $random(s);
    return data_t'(r);
  endfunction

  function automatic int size_bytes(input size_t s);
    return (s == SIZE_BYTE) ? 1 : ((s == SIZE_HALF) ? 2 : 4);
  endfunction

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_rdata(input string what, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_be(input string what, input be_t exp, input be_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("ERROR %s %s: expected %b actual %b", test_name, what, exp, act);
      abort_run();
    end
  endtask

  // Reference model, applied when an operation is accepted
  task automatic model_accept();
    addr_t      eff;
    data_t      val;
    logic [7:0] idx;
    int         n;
    eff = base_i + offset_i;
    n   = size_bytes(size_i);
    val = '0;
    for (int i = 0; i < n; i++) begin
      idx = eff[7:0] + 8'(i);
      if (we_i) model_bytes[idx] = 8'(wdata_i >> (8 * i));
      else val = val | (data_t'(model_bytes[idx]) << (8 * i));
    end
    // Sign fill above the loaded bytes
    if (!we_i && sext_i && 1'(val >> (8 * n - 1))) begin
      val = val | ~((32'd1 << (8 * n)) - 32'd1);
    end
    exp_we.push_back(we_i);
    exp_data.push_back(val);
  endtask

  //////////////////////////////////////////////////
  // Memory responder and result monitor
  //////////////////////////////////////////////////

  initial begin
    addr_t      eff;
    be_t        be_exp;
    data_t      rd;
    data_t      r;
    logic [7:0] idx;
    logic       last;
    logic       phase_q;
    logic       gnt_next;
    int         n, lat, due, last_due, cyc, outstanding;
    bus_seed    = ~SEED;
    bus_gnt_i   = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i = '0;
    phase_q     = 1'b0;
    cyc         = 0;
    last_due    = 0;
    outstanding = 0;
    r           = '0;
    for (int i = 0; i < 256; i++) begin
      mem_bytes[8'(i)]   = 8'(i * 29 + 7);
      model_bytes[8'(i)] = 8'(i * 29 + 7);
    end
    forever begin
      @(posedge clk);
      cyc++;
      if (valid_i && ready_o) model_accept();
      if (bus_req_o && bus_gnt_i) begin
        if (outstanding >= 2) begin
          $display("Bus transaction granted while two were already outstanding");
          abort_run();
        end
        eff  = base_i + offset_i;
        n    = size_bytes(size_i);
        last = phase_q || ((int'(eff[1:0]) + n) <= 4);
        // First phase at the address, second at the next word from lane 0
        if (!phase_q) begin
          check_addr("first phase address", eff, bus_addr_o);
          be_exp = be_t'(((1 << n) - 1) << eff[1:0]);
        end else begin
          check_addr("second phase address", {eff[31:2], 2'b00} + 32'd4, bus_addr_o);
          be_exp = be_t'((1 << (int'(eff[1:0]) + n - 4)) - 1);
        end
        check_be("byte enables", be_exp, bus_be_o);
        check_flag("write enable", we_i, bus_we_o);
        check_flag("ready on last phase", last, ready_o);
        phase_q = !last;
        rd = '0;
        for (int lane = 0; lane < 4; lane++) begin
          idx = {bus_addr_o[7:2], 2'(lane)};
          if (1'(bus_be_o >> lane)) begin
            if (bus_we_o) mem_bytes[idx] = 8'(bus_wdata_o >> (8 * lane));
            rd = rd | (data_t'(mem_bytes[idx]) << (8 * lane));
          end else begin
            // Disabled lanes carry junk
            rd = rd | (data_t'(8'(rand32(bus_seed))) << (8 * lane));
          end
        end
        lat = slow_mode ? 3 : 1 + int'(rand32(bus_seed) % 32'd3);
        due = cyc + lat;
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        rsp_data.push_back(rd);
        rsp_due.push_back(due);
        outstanding++;
      end
      if (bus_rvalid_i) outstanding--;
      if (rvalid_o) begin
        if (exp_we.size() == 0) begin
          $display("Result strobe seen with no operation pending");
          abort_run();
        end
        if (!exp_we[0]) check_rdata("load data", exp_data[0], rdata_o);
        void'(exp_we.pop_front());
        void'(exp_data.pop_front());
      end
      r = rand32(bus_seed);
      // Grant decision taken on the rising edge, driven on the falling one
      gnt_next = slow_mode || (r[1:0] != 2'd0);
      @(negedge clk);
      bus_gnt_i = gnt_next;
      if (rsp_due.size() != 0 && rsp_due[0] <= cyc + 1) begin
        bus_rvalid_i = 1'b1;
        bus_rdata_i  = rsp_data.pop_front();
        void'(rsp_due.pop_front());
      end else begin
        bus_rvalid_i = 1'b0;
        bus_rdata_i  = r;
      end
    end
  end

  //////////////////////////////////////////////////
  // Core stimulus
  //////////////////////////////////////////////////

  // Present one operation and hold it until accepted
  task automatic run_op(input logic we, input logic [7:0] eff, input size_t size,
                        input logic sext, input data_t wdata);
    addr_t base;
    int    t;
    base     = rand32(seed);
    valid_i  = 1'b1;
    base_i   = base;
    offset_i = {24'd0, eff} - base;
    we_i     = we;
    size_i   = size;
    sext_i   = sext;
    wdata_i  = wdata;
    t = 0;
    @(posedge clk);
    while (!ready_o && t < 200) begin
      @(posedge clk);
      t++;
    end
    if (!ready_o) begin
      $display("Timeout waiting for the LSU to accept an operation at %h", eff);
      abort_run();
    end
    @(negedge clk);
    valid_i = 1'b0;
  endtask

  // Random access followed by a load of the same bytes
  task automatic random_pair(input logic aligned);
    data_t      r;
    size_t      size;
    logic [7:0] eff;
    r    = rand32(seed);
    size = (r[1:0] == 2'd3) ? SIZE_WORD : r[1:0];
    eff  = 8'(rand32(seed) % 32'd252);
    if (aligned) eff = eff & ~(8'(size_bytes(size)) - 8'd1);
    run_op(r[2], eff, size, r[3], rand32(seed));
    run_op(1'b0, eff, size, r[4], '0);
    if (r[5]) @(negedge clk);
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    @(posedge clk);
    while ((busy_o || exp_we.size() != 0) && t < 100) begin
      @(posedge clk);
      t++;
    end
    if (busy_o || exp_we.size() != 0) begin
      $display("Timeout waiting for outstanding operations to drain");
      abort_run();
    end
    @(negedge clk);
  endtask

  initial begin
    seed      = SEED;
    rst_n     = 1'b0;
    valid_i   = 1'b0;
    base_i    = '0;
    offset_i  = '0;
    we_i      = 1'b0;
    size_i    = SIZE_BYTE;
    sext_i    = 1'b0;
    wdata_i   = '0;
    test_name = "reset";
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_flag("ready after reset", 1'b0, ready_o);
    check_flag("rvalid after reset", 1'b0, rvalid_o);
    check_flag("busy after reset", 1'b0, busy_o);
    @(negedge clk);

    test_name = "aligned";
    repeat (40) random_pair(1'b1);
    wait_idle();

    test_name = "misaligned";
    repeat (60) random_pair(1'b0);
    wait_idle();

    // Immediate grants, slow responses
    test_name = "depth";
    slow_mode = 1'b1;
    repeat (40) random_pair(1'b0);
    wait_idle();

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: src/lsu_top.sv
// Load/store unit top level

`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Core request
  input  logic  valid_i,
  output logic  ready_o,
  input  addr_t base_i,
  input  addr_t offset_i,
  input  logic  we_i,
  input  size_t size_i,
  input  logic  sext_i,
  input  data_t wdata_i,
  // Data bus
  output logic  bus_req_o,
  output addr_t bus_addr_o,
  output logic  bus_we_o,
  output be_t   bus_be_o,
  output data_t bus_wdata_o,
  input  logic  bus_gnt_i,
  input  logic  bus_rvalid_i,
  input  data_t bus_rdata_i,
  // Result
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  busy_o
);

  // Decode to bus control
  addr_t   phase_addr;
  be_t     phase_be;
  data_t   phase_wdata;
  logic    phase_split;
  offset_t phase_offset;
  logic    split_phase;

  // Bus control to alignment
  logic    resp_valid;
  logic    resp_last;
  size_t   resp_size;
  logic    resp_sext;
  offset_t resp_offset;
  logic    resp_we;
  data_t   resp_rdata;

  lsu_req_decode i_req_decode (
    .base_i        (base_i),
    .offset_i      (offset_i),
    .size_i        (size_i),
    .wdata_i       (wdata_i),
    .split_phase_i (split_phase),
    .addr_o        (phase_addr),
    .be_o          (phase_be),
    .wdata_o       (phase_wdata),
    .split_o       (phase_split),
    .offset_o      (phase_offset)
  );

  lsu_bus_ctrl i_bus_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .we_i          (we_i),
    .size_i        (size_i),
    .sext_i        (sext_i),
    .addr_i        (phase_addr),
    .be_i          (phase_be),
    .wdata_i       (phase_wdata),
    .split_i       (phase_split),
    .offset_i      (phase_offset),
    .bus_gnt_i     (bus_gnt_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .bus_rdata_i   (bus_rdata_i),
    .ready_o       (ready_o),
    .busy_o        (busy_o),
    .split_phase_o (split_phase),
    .bus_req_o     (bus_req_o),
    .bus_addr_o    (bus_addr_o),
    .bus_we_o      (bus_we_o),
    .bus_be_o      (bus_be_o),
    .bus_wdata_o   (bus_wdata_o),
    .resp_valid_o  (resp_valid),
    .resp_last_o   (resp_last),
    .resp_size_o   (resp_size),
    .resp_sext_o   (resp_sext),
    .resp_offset_o (resp_offset),
    .resp_we_o     (resp_we),
    .resp_rdata_o  (resp_rdata)
  );

  lsu_rdata_align i_rdata_align (
    .clk           (clk),
    .rst_n         (rst_n),
    .resp_valid_i  (resp_valid),
    .resp_last_i   (resp_last),
    .resp_size_i   (resp_size),
    .resp_sext_i   (resp_sext),
    .resp_offset_i (resp_offset),
    .resp_we_i     (resp_we),
    .resp_rdata_i  (resp_rdata),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o)
  );

endmodule

// File: src/lsu_rdata_align.sv
// Load data realignment

`timescale 1ns/1ps

module lsu_rdata_align import lsu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    resp_valid_i,
  input  logic    resp_last_i,
  input  size_t   resp_size_i,
  input  logic    resp_sext_i,
  input  offset_t resp_offset_i,
  input  logic    resp_we_i,
  input  data_t   resp_rdata_i,
  output logic    rvalid_o,
  output data_t   rdata_o
);

  // First half of a split access
  logic    pend_q;
  offset_t pend_off_q;
  data_t   rdata_q;

  logic [63:0] rdata_full;
  logic [63:0] rdata_shift;

  // Pending flag, set by the first response of a split
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= 1'b0;
    end else if (resp_valid_i) begin
      pend_q <= !resp_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (resp_valid_i && !resp_last_i) begin
      pend_off_q <= resp_offset_i;
      if (!resp_we_i) rdata_q <= resp_rdata_i;
    end
  end

  //////////////////////////////////////////////////
  // Join, shift and extend
  //////////////////////////////////////////////////

  // Unsplit words are doubled so shifted bytes wrap around
  assign rdata_full  = pend_q ? {resp_rdata_i, rdata_q} : {resp_rdata_i, resp_rdata_i};
  assign rdata_shift = rdata_full >> {resp_offset_i, 3'b000};

  always_comb begin
    case (resp_size_i)
      SIZE_BYTE: begin
        rdata_o = {{24{resp_sext_i && rdata_shift[7]}}, rdata_shift[7:0]};
      end
      SIZE_HALF: begin
        rdata_o = {{16{resp_sext_i && rdata_shift[15]}}, rdata_shift[15:0]};
      end
      default: begin
        rdata_o = rdata_shift[31:0];
      end
    endcase
  end

  // One strobe per operation
  assign rvalid_o = resp_valid_i && resp_last_i;

  // Both halves of a split carry the same byte offset
  a_split_offset: assert property (@(posedge clk) disable iff (!rst_n)
    (resp_valid_i && pend_q) |-> (resp_offset_i == pend_off_q));

endmodule

// File: src/lsu_bus_ctrl.sv
// Load/store bus control

`timescale 1ns/1ps

module lsu_bus_ctrl import lsu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    valid_i,
  input  logic    we_i,
  input  size_t   size_i,
  input  logic    sext_i,
  input  addr_t   addr_i,
  input  be_t     be_i,
  input  data_t   wdata_i,
  input  logic    split_i,
  input  offset_t offset_i,
  input  logic    bus_gnt_i,
  input  logic    bus_rvalid_i,
  input  data_t   bus_rdata_i,
  output logic    ready_o,
  output logic    busy_o,
  output logic    split_phase_o,
  output logic    bus_req_o,
  output addr_t   bus_addr_o,
  output logic    bus_we_o,
  output be_t     bus_be_o,
  output data_t   bus_wdata_o,
  output logic    resp_valid_o,
  output logic    resp_last_o,
  output size_t   resp_size_o,
  output logic    resp_sext_o,
  output offset_t resp_offset_o,
  output logic    resp_we_o,
  output data_t   resp_rdata_o
);

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic grant;
  logic split_q;

  // Info queue, one entry per granted transaction
  size_t   q_size   [LSU_DEPTH];
  logic    q_sext   [LSU_DEPTH];
  offset_t q_offset [LSU_DEPTH];
  logic    q_we     [LSU_DEPTH];
  logic    q_last   [LSU_DEPTH];
  logic    wr_ptr_q;
  logic    rd_ptr_q;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  // Hold back while two transactions are in flight
  assign bus_req_o   = valid_i && (cnt_q < LSU_DEPTH);
  assign grant       = bus_req_o && bus_gnt_i;
  assign bus_addr_o  = addr_i;
  assign bus_we_o    = we_i;
  assign bus_be_o    = be_i;
  assign bus_wdata_o = wdata_i;

  // Operation done once its last phase is granted
  assign ready_o = grant && !split_i;
  assign busy_o  = valid_i || (cnt_q != 2'd0);

  // Split phase tracking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      split_q <= 1'b0;
    end else if (grant) begin
      split_q <= split_i;
    end
  end

  assign split_phase_o = split_q;

  //////////////////////////////////////////////////
  // Outstanding count
  //////////////////////////////////////////////////

  always_comb begin
    case ({grant, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Queue pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (grant) wr_ptr_q <= !wr_ptr_q;
      if (bus_rvalid_i) rd_ptr_q <= !rd_ptr_q;
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (grant) begin
      q_size[wr_ptr_q]   <= size_i;
      q_sext[wr_ptr_q]   <= sext_i;
      q_offset[wr_ptr_q] <= offset_i;
      q_we[wr_ptr_q]     <= we_i;
      q_last[wr_ptr_q]   <= !split_i;
    end
  end

  // Response info from the queue head
  assign resp_valid_o  = bus_rvalid_i;
  assign resp_rdata_o  = bus_rdata_i;
  assign resp_size_o   = q_size[rd_ptr_q];
  assign resp_sext_o   = q_sext[rd_ptr_q];
  assign resp_offset_o = q_offset[rd_ptr_q];
  assign resp_we_o     = q_we[rd_ptr_q];
  assign resp_last_o   = q_last[rd_ptr_q];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= LSU_DEPTH);

  // Memory only answers granted transactions
  a_no_stray_resp: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != 2'd0));

  a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o |-> (bus_be_o != 4'b0000));

endmodule

// File: src/lsu_req_decode.sv
// Load/store request decode

`timescale 1ns/1ps

module lsu_req_decode import lsu_pkg::*; (
  input  addr_t   base_i,
  input  addr_t   offset_i,
  input  size_t   size_i,
  input  data_t   wdata_i,
  input  logic    split_phase_i,
  output addr_t   addr_o,
  output be_t     be_o,
  output data_t   wdata_o,
  output logic    split_o,
  output offset_t offset_o
);

  // Effective byte address of the access
  addr_t   eff_addr;
  offset_t off;

  assign eff_addr = base_i + offset_i;
  assign off      = eff_addr[1:0];
  assign offset_o = off;

  // Second phase goes to the next word, lane 0 upwards
  assign addr_o = split_phase_i ? ({eff_addr[31:2], 2'b00} + 32'd4) : eff_addr;

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  always_comb begin
    be_o = 4'b0000;
    case (size_i)
      SIZE_BYTE: begin
        be_o = 4'b0001 << off;
      end
      SIZE_HALF: begin
        if (split_phase_i) begin
          // Only the upper byte spills into the next word
          be_o = 4'b0001;
        end else begin
          case (off)
            2'd0:    be_o = 4'b0011;
            2'd1:    be_o = 4'b0110;
            2'd2:    be_o = 4'b1100;
            default: be_o = 4'b1000;
          endcase
        end
      end
      default: begin
        if (split_phase_i) begin
          // Remaining low lanes of the word
          case (off)
            2'd1:    be_o = 4'b0001;
            2'd2:    be_o = 4'b0011;
            default: be_o = 4'b0111;
          endcase
        end else begin
          be_o = 4'b1111 << off;
        end
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Write data rotation
  //////////////////////////////////////////////////

  // Rotate left so byte 0 lands on lane off; wrapped bytes feed phase two
  always_comb begin
    case (off)
      2'd0:    wdata_o = wdata_i;
      2'd1:    wdata_o = {wdata_i[23:0], wdata_i[31:24]};
      2'd2:    wdata_o = {wdata_i[15:0], wdata_i[31:16]};
      default: wdata_o = {wdata_i[7:0],  wdata_i[31:8]};
    endcase
  end

  // Split decision
  // Only raised in the first phase
  always_comb begin
    split_o = 1'b0;
    if (!split_phase_i) begin
      if ((size_i == SIZE_WORD) && (off != 2'd0)) begin
        split_o = 1'b1;
      end
      if ((size_i == SIZE_HALF) && (off == 2'd3)) begin
        split_o = 1'b1;
      end
    end
  end

endmodule

// File: src/lsu_pkg.sv
// Load/store unit shared definitions

package lsu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Byte address
  typedef logic [31:0] addr_t;

  // One bus word
  typedef logic [31:0] data_t;

  // Byte enables, one bit per lane
  typedef logic [3:0]  be_t;

  // Access size code
  typedef logic [1:0]  size_t;

  // Byte offset within a word
  typedef logic [1:0]  offset_t;

  // Outstanding transaction count
  typedef logic [1:0]  cnt_t;

  //////////////////////////////////////////////////
  // Size codes and depth
  //////////////////////////////////////////////////

  localparam size_t SIZE_BYTE = 2'd0;
  localparam size_t SIZE_HALF = 2'd1;
  localparam size_t SIZE_WORD = 2'd2;

  // At most two bus transactions in flight
  localparam cnt_t  LSU_DEPTH = 2'd2;

endpackage
